/* Makefile */
# Verilator build and run for the data cache testbench
VERILATOR ?= verilator
TOP       ?= dcacheTb
FILELIST  ?= dcache.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(shell sed -e '/^+/d' $(FILELIST)) include/dcache_defs.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/dcacheMemory.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcacheMemory (
  input  logic             clk,
  input  logic             reset,
  input  logic             memValid,
  output logic             memReady,
  input  dcachePkg::memReq mem,
  output logic [31:0]      memRdata
);

  localparam int WORDS = 1 << (`DCACHE_ADDR_BITS - 2);

  logic [31:0] store [WORDS];

  // Every word gets a value built from its full address
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      store[i] = (i * 32'h9e3779b1) ^ {i[15:0], ~i[15:0]};
    end
    memReady = 1'b0;
  end

  // Random accept delay, changed on the falling edge
  always @(negedge clk) begin
    if (reset) begin
      memReady = 1'b0;
    end else begin
      memReady = ($urandom % 3) == 0;
    end
  end

  // Read data comes back with the accept
  assign memRdata = store[mem.addr];

  always @(posedge clk) begin
    if (memValid && memReady && mem.write) begin
      store[mem.addr] <= mem.wdata;
    end
  end

endmodule

/* bench/dcacheTb.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcacheTb;

  localparam int NUM_OPS = 400;
  localparam int MEM_WORDS = 1 << (`DCACHE_ADDR_BITS - 2);
  // Worst op is a flush of every dirty way with slow memory
  localparam int CYCLE_LIMIT = (NUM_OPS + 3) * 700;
  localparam logic [7:0] TAGS [3] = '{8'h11, 8'h5c, 8'hd3};

  logic              clk, reset, reqValid, reqReady, respValid, respReady;
  logic              memValid, memReady;
  logic [31:0]       memRdata;
  dcachePkg::cpuReq  req;
  dcachePkg::cpuResp resp;
  dcachePkg::memReq  mem;

  // Reference model of memory contents and of the tag state
  logic [31:0]       model [MEM_WORDS];
  logic [7:0]        mTag [`DCACHE_SETS][2];
  logic              mValid [`DCACHE_SETS][2];
  logic              mDirty [`DCACHE_SETS][2];
  logic              mLru [`DCACHE_SETS];
  dcachePkg::memReq  beats[$];
  dcachePkg::memReq  expBeats[$];
  int                cycles = 0;

  dcacheTop DUT (
    .clk, .reset, .reqValid, .reqReady, .req, .respValid, .respReady, .resp,
    .memValid, .memReady, .mem, .memRdata
  );

  dcacheMemory memInst (
    .clk, .reset, .memValid, .memReady, .mem, .memRdata
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Every accepted bus beat
  always @(posedge clk) begin
    if (memValid && memReady) begin
      beats.push_back(mem);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      stopRun($sformatf("Timeout after %0d cycles with the cache still busy", cycles));
    end
  end

  task automatic stopRun(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic checkResp(input string name, input dcachePkg::cpuResp exp,
                           input dcachePkg::cpuResp act);
    if (exp !== act) begin
      stopRun($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      stopRun($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkBeat(input string name, input dcachePkg::memReq exp,
                           input dcachePkg::memReq act);
    if (exp !== act) begin
      stopRun($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkBeats(input string name);
    if (beats.size() != expBeats.size()) begin
      stopRun($sformatf("%s: saw %0d memory beats where %0d were due",
                        name, beats.size(), expBeats.size()));
    end
    foreach (expBeats[i]) begin
      checkBeat(name, expBeats[i], beats[i]);
    end
  endtask

  // Four beats of one block in word order
  task automatic expectBlock(input logic write, input logic [7:0] tag, input logic [3:0] set);
    dcachePkg::memReq b;
    for (int w = 0; w < `DCACHE_WORDS; w++) begin
      b.write = write;
      b.addr  = {tag, set, 2'(w)};
      b.wdata = write ? model[b.addr] : 32'h0;
      expBeats.push_back(b);
    end
  endtask

  // Send one request, then drain its response under random back-pressure
  task automatic runOp(input string name, input dcachePkg::cpuReq r,
                       input dcachePkg::cpuResp exp, output int lat);
    dcachePkg::cpuResp got;
    beats.delete();
    req      = r;
    reqValid = 1'b1;
    while (!reqReady) begin
      @(negedge clk);
    end
    @(posedge clk);
    lat = 0;
    do begin
      @(negedge clk);
      reqValid = 1'b0;
      lat++;
    end while (!respValid);
    got = resp;
    checkResp(name, exp, got);
    forever begin
      if (reqReady !== 1'b0) begin
        stopRun("A new request could be taken while a response was still pending");
      end
      checkResp("held response", got, resp);
      respReady = ($urandom % 3) != 0;
      @(posedge clk);
      if (respReady) begin
        break;
      end
      @(negedge clk);
    end
    @(negedge clk);
    respReady = 1'b0;
  endtask

  task automatic doAccess(input logic isStore);
    dcachePkg::cpuReq  r;
    dcachePkg::cpuResp exp;
    logic [7:0]        t;
    logic [3:0]        s;
    logic [13:0]       wa;
    int                hitWay, lat;
    logic              wasHit;
    t = TAGS[$urandom % 3];
    s = 4'($urandom % 4);
    r.op = isStore ? dcachePkg::OP_STORE : dcachePkg::OP_LOAD;
    r.addr.look.tag     = t;
    r.addr.look.index   = s;
    r.addr.look.word    = 2'($urandom % 4);
    r.addr.look.byteSel = 2'b00;
    r.wdata    = $urandom;
    r.byteMask = 4'($urandom % 16);
    wa = {t, s, r.addr.look.word};
    expBeats.delete();
    hitWay = -1;
    for (int k = 0; k < 2; k++) begin
      if (mValid[s][k] && mTag[s][k] == t) begin
        hitWay = k;
      end
    end
    wasHit = hitWay >= 0;
    // Miss replaces the LRU way, writing it back first if dirty
    if (!wasHit) begin
      hitWay = int'(mLru[s]);
      if (mValid[s][hitWay] && mDirty[s][hitWay]) begin
        expectBlock(1'b1, mTag[s][hitWay], s);
      end
      expectBlock(1'b0, t, s);
      mTag[s][hitWay]   = t;
      mValid[s][hitWay] = 1'b1;
      mDirty[s][hitWay] = 1'b0;
    end
    exp.op    = r.op;
    exp.rdata = isStore ? 32'h0 : model[wa];
    if (isStore) begin
      for (int b = 0; b < 4; b++) begin
        if (r.byteMask[b]) begin
          model[wa][b*8 +: 8] = r.wdata[b*8 +: 8];
        end
      end
      mDirty[s][hitWay] = 1'b1;
    end
    mLru[s] = (hitWay == 0);
    runOp(isStore ? "store" : "load", r, exp, lat);
    checkBeats(wasHit ? "hit traffic" : "miss traffic");
    if (wasHit) begin
      checkWord("hit latency", 32'd2, 32'(lat));
    end
  endtask

  // Each set writes back its LRU way first, then the other one
  task automatic doFlush(input string name);
    dcachePkg::cpuReq  r;
    dcachePkg::cpuResp exp;
    int                v, lat;
    expBeats.delete();
    for (int s = 0; s < `DCACHE_SETS; s++) begin
      for (int k = 0; k < 2; k++) begin
        v = (k == 0) ? int'(mLru[s]) : int'(!mLru[s]);
        if (mValid[s][v] && mDirty[s][v]) begin
          expectBlock(1'b1, mTag[s][v], 4'(s));
          mDirty[s][v] = 1'b0;
        end
      end
    end
    r         = '0;
    r.op      = dcachePkg::OP_FLUSH;
    exp.op    = dcachePkg::OP_FLUSH;
    exp.rdata = 32'h0;
    runOp(name, r, exp, lat);
    checkBeats(name);
  endtask

  initial begin
    int sel;
    void'($urandom(32'h8e6eb203));
    reset     = 1'b1;
    reqValid  = 1'b0;
    req       = '0;
    respReady = 1'b0;
    for (int s = 0; s < `DCACHE_SETS; s++) begin
      mLru[s] = 1'b0;
      for (int k = 0; k < 2; k++) begin
        mTag[s][k]   = 8'h0;
        mValid[s][k] = 1'b0;
        mDirty[s][k] = 1'b0;
      end
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      model[i] = memInst.store[i];
    end
    for (int n = 0; n < NUM_OPS; n++) begin
      sel = int'($urandom % 32);
      if (sel == 0) begin
        doFlush("random flush");
      end else begin
        doAccess(sel[0]);
      end
    end
    doFlush("final flush");
    for (int i = 0; i < MEM_WORDS; i++) begin
      checkWord("flush contents", model[i], memInst.store[i]);
    end
    // All lines are clean now, so no write beats are due
    doFlush("second flush");
    $display("TB PASSED");
    $finish;
  end

endmodule

/* dcache.f */
+incdir+include
logic/dcachePkg.sv
logic/dcacheTagArray.sv
logic/dcacheDataArray.sv
logic/dcacheController.sv
logic/dcacheResponse.sv
logic/dcacheTop.sv
bench/dcacheMemory.sv
bench/dcacheTb.sv

/* include/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Byte address width seen by the cache
`define DCACHE_ADDR_BITS 16

// Two ways of this many sets
`define DCACHE_SETS 16

// 32-bit words per block
`define DCACHE_WORDS 4

// Address less index, word and byte bits
`define DCACHE_TAG_BITS 8

`endif

/* logic/dcacheController.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcacheController (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             reqValid,
  output logic                             reqReady,
  input  dcachePkg::cpuReq                 req,
  input  logic                             respBusy,
  input  dcachePkg::lookup                 look,
  output logic [$clog2(`DCACHE_SETS)-1:0]  index,
  output logic [`DCACHE_TAG_BITS-1:0]      newTag,
  output logic                             tagWe,
  output logic                             tagWay,
  output logic                             setDirty,
  output logic                             clearDirty,
  output logic                             touchWay,
  output logic                             touch,
  output logic [$clog2(`DCACHE_WORDS)-1:0] word,
  output logic                             way,
  output logic                             dataWe,
  output logic [3:0]                       mask,
  output logic [31:0]                      dataWdata,
  input  logic [31:0]                      cacheRdata,
  output logic                             memValid,
  input  logic                             memReady,
  output dcachePkg::memReq                 mem,
  input  logic [31:0]                      memRdata,
  output logic                             finish,
  output dcachePkg::cpuResp                finishResp
);

  typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, REFILL, FLUSH} ctrlState;

  ctrlState                         state, nextState;
  dcachePkg::cpuReq                 reqR;
  logic [$clog2(`DCACHE_WORDS)-1:0] count;
  logic [$clog2(`DCACHE_SETS)-1:0]  flushSet;
  // Which of the two ways of the set the flush is on
  logic                             flushSide;
  logic                             accept, flushing, anyHit, isStore;
  logic                             victimDirty, beatDone, lastBeat, pickWay, flushStep;

  assign accept      = reqValid & reqReady;
  assign flushing    = reqR.op == dcachePkg::OP_FLUSH;
  assign isStore     = reqR.op == dcachePkg::OP_STORE;
  assign anyHit      = |look.hit;
  assign victimDirty = look.valid[look.lru] & look.dirty[look.lru];
  assign beatDone    = memValid & memReady;
  assign lastBeat    = beatDone && (count == `DCACHE_WORDS - 1);
  assign flushStep   = (state == FLUSH) & ~victimDirty;

  // Hit way on a lookup, otherwise the LRU way is the one moved
  assign pickWay = (state == LOOKUP) ? look.hit[1] : look.lru;

  assign reqReady = (state == IDLE) & ~respBusy;
  assign index    = flushing ? flushSet : reqR.addr.look.index;
  assign newTag   = reqR.addr.look.tag;
  assign tagWay   = pickWay;
  assign touchWay = pickWay;
  assign way      = pickWay;
  assign word     = (state == LOOKUP) ? reqR.addr.look.word : count;
  assign memValid = (state == WRITEBACK) | (state == REFILL);

  assign tagWe      = (state == REFILL) & lastBeat;
  assign clearDirty = (state == WRITEBACK) & lastBeat;
  assign setDirty   = (state == LOOKUP) & anyHit & isStore;
  // In a flush the touch flips LRU to the other way and back again
  assign touch      = ((state == LOOKUP) & anyHit) | flushStep;

  assign dataWe    = ((state == LOOKUP) & anyHit & isStore) | ((state == REFILL) & beatDone);
  assign mask      = (state == LOOKUP) ? reqR.byteMask : 4'hf;
  assign dataWdata = (state == LOOKUP) ? reqR.wdata : memRdata;

  assign finish = ((state == LOOKUP) & anyHit) |
                  (flushStep && flushSide && (flushSet == `DCACHE_SETS - 1));
  assign finishResp.op    = reqR.op;
  assign finishResp.rdata = (reqR.op == dcachePkg::OP_LOAD) ? cacheRdata : '0;

  // Write-back uses the stored tag, refill the requested block
  assign mem.write = state == WRITEBACK;
  assign mem.addr  = (state == WRITEBACK) ? {look.victimTag, look.index, count} :
                                            {reqR.addr.bus.block, count};
  assign mem.wdata = (state == WRITEBACK) ? cacheRdata : '0;

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (accept) begin
          nextState = (req.op == dcachePkg::OP_FLUSH) ? FLUSH : LOOKUP;
        end
      end
      LOOKUP: begin
        if (anyHit) begin
          nextState = IDLE;
        end else if (victimDirty) begin
          nextState = WRITEBACK;
        end else begin
          nextState = REFILL;
        end
      end
      WRITEBACK: begin
        if (lastBeat) begin
          nextState = flushing ? FLUSH : REFILL;
        end
      end
      // Retry the lookup against the new block
      REFILL: begin
        if (lastBeat) begin
          nextState = LOOKUP;
        end
      end
      FLUSH: begin
        if (victimDirty) begin
          nextState = WRITEBACK;
        end else if (finish) begin
          nextState = IDLE;
        end
      end
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqR <= req;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      count     <= '0;
      flushSet  <= '0;
      flushSide <= 1'b0;
    end else begin
      state <= nextState;
      // Four beats wrap the counter back to zero
      if (beatDone) begin
        count <= count + 1'b1;
      end
      if (accept) begin
        flushSet  <= '0;
        flushSide <= 1'b0;
      end else if (flushStep) begin
        flushSide <= ~flushSide;
        if (flushSide) begin
          flushSet <= flushSet + 1'b1;
        end
      end
    end
  end

  // A refill never lands on a dirty line
  assert property (@(posedge clk) disable iff (reset)
    (state == REFILL) |-> !victimDirty);

  // Bus beat held until memory takes it
  assert property (@(posedge clk) disable iff (reset)
    memValid && !memReady |=> memValid && $stable(mem));

endmodule

/* logic/dcacheDataArray.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcacheDataArray (
  input  logic                             clk,
  input  logic [$clog2(`DCACHE_SETS)-1:0]  index,
  input  logic [$clog2(`DCACHE_WORDS)-1:0] word,
  input  logic                             way,
  input  logic                             we,
  input  logic [3:0]                       mask,
  input  logic [31:0]                      wdata,
  output logic [31:0]                      rdata
);

  logic [31:0] blocks [2][`DCACHE_SETS][`DCACHE_WORDS];

  // Only the masked byte lanes change
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          blocks[way][index][word][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  assign rdata = blocks[way][index][word];

endmodule

/* logic/dcachePkg.sv */
`include "dcache_defs.svh"

package dcachePkg;

  typedef enum logic [1:0] {
    OP_LOAD  = 2'd0,
    OP_STORE = 2'd1,
    OP_FLUSH = 2'd2
  } opKind;

  // Address as the tag compare sees it
  typedef struct packed {
    logic [`DCACHE_TAG_BITS-1:0]      tag;
    logic [$clog2(`DCACHE_SETS)-1:0]  index;
    logic [$clog2(`DCACHE_WORDS)-1:0] word;
    logic [1:0]                       byteSel;
  } lookAddr;

  // Same address as the memory bus sees it
  typedef struct packed {
    logic [`DCACHE_ADDR_BITS-$clog2(`DCACHE_WORDS)-3:0] block;
    logic [$clog2(`DCACHE_WORDS)-1:0]                   word;
    logic [1:0]                                         byteSel;
  } busAddr;

  typedef union packed {
    lookAddr look;
    busAddr  bus;
  } cacheAddr;

  typedef struct packed {
    opKind       op;
    cacheAddr    addr;
    logic [31:0] wdata;
    logic [3:0]  byteMask;
  } cpuReq;

  typedef struct packed {
    opKind       op;
    logic [31:0] rdata;
  } cpuResp;

  // One word beat on the memory bus
  typedef struct packed {
    logic                         write;
    logic [`DCACHE_ADDR_BITS-3:0] addr;
    logic [31:0]                  wdata;
  } memReq;

  typedef struct packed {
    logic [1:0]                      hit;
    logic [1:0]                      valid;
    logic [1:0]                      dirty;
    logic                            lru;
    logic [`DCACHE_TAG_BITS-1:0]     victimTag;
    logic [$clog2(`DCACHE_SETS)-1:0] index;
  } lookup;

endpackage

/* logic/dcacheResponse.sv */
`timescale 1ns/10ps

module dcacheResponse (
  input  logic              clk,
  input  logic              reset,
  input  logic              finish,
  input  dcachePkg::cpuResp finishResp,
  output logic              respValid,
  input  logic              respReady,
  output dcachePkg::cpuResp resp,
  output logic              respBusy
);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      respValid <= 1'b0;
    end else if (finish) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  // Held until the CPU takes it
  always_ff @(posedge clk) begin
    if (finish) begin
      resp <= finishResp;
    end
  end

  assign respBusy = respValid;

  // Controller must wait for the pending response to drain
  assert property (@(posedge clk) disable iff (reset)
    finish |-> !respValid);

endmodule

/* logic/dcacheTagArray.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcacheTagArray (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [$clog2(`DCACHE_SETS)-1:0] index,
  input  logic [`DCACHE_TAG_BITS-1:0]     tag,
  output dcachePkg::lookup                look,
  input  logic                            tagWe,
  input  logic                            tagWay,
  input  logic [`DCACHE_TAG_BITS-1:0]     newTag,
  input  logic                            setDirty,
  input  logic                            clearDirty,
  input  logic                            touchWay,
  input  logic                            touch
);

  logic [`DCACHE_TAG_BITS-1:0] tags [2][`DCACHE_SETS];
  logic [`DCACHE_SETS-1:0]     valid [2];
  logic [`DCACHE_SETS-1:0]     dirty [2];
  // Per set, the way to evict next
  logic [`DCACHE_SETS-1:0]     lru;

  always_ff @(posedge clk) begin
    if (tagWe) begin
      tags[tagWay][index] <= newTag;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      valid[0] <= '0;
      valid[1] <= '0;
      dirty[0] <= '0;
      dirty[1] <= '0;
      lru      <= '0;
    end else begin
      // Refilled block arrives clean
      if (tagWe) begin
        valid[tagWay][index] <= 1'b1;
        dirty[tagWay][index] <= 1'b0;
      end
      if (setDirty) begin
        dirty[tagWay][index] <= 1'b1;
      end
      if (clearDirty) begin
        dirty[tagWay][index] <= 1'b0;
      end
      // Touched way becomes most recent
      if (touch) begin
        lru[index] <= ~touchWay;
      end
    end
  end

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      look.hit[w]   = valid[w][index] && (tags[w][index] == tag);
      look.valid[w] = valid[w][index];
      look.dirty[w] = dirty[w][index];
    end
    look.lru       = lru[index];
    look.victimTag = tags[lru[index]][index];
    look.index     = index;
  end

  // A tag lives in at most one way of a set
  assert property (@(posedge clk) disable iff (reset)
    !(look.hit[0] && look.hit[1]));

endmodule

/* logic/dcacheTop.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcacheTop (
  input  logic              clk,
  input  logic              reset,
  input  logic              reqValid,
  output logic              reqReady,
  input  dcachePkg::cpuReq  req,
  output logic              respValid,
  input  logic              respReady,
  output dcachePkg::cpuResp resp,
  output logic              memValid,
  input  logic              memReady,
  output dcachePkg::memReq  mem,
  input  logic [31:0]       memRdata
);

  dcachePkg::lookup                 look;
  dcachePkg::cpuResp                finishResp;
  logic [$clog2(`DCACHE_SETS)-1:0]  index;
  logic [`DCACHE_TAG_BITS-1:0]      newTag;
  logic [$clog2(`DCACHE_WORDS)-1:0] word;
  logic [3:0]                       mask;
  logic [31:0]                      dataWdata, cacheRdata;
  logic                             tagWe, tagWay, setDirty, clearDirty, touchWay, touch;
  logic                             way, dataWe, finish, respBusy;

  // Compare and refill both use the captured request tag
  dcacheTagArray tagArray (
    .clk, .reset, .index, .tag(newTag), .look, .tagWe, .tagWay, .newTag,
    .setDirty, .clearDirty, .touchWay, .touch
  );

  dcacheDataArray dataArray (
    .clk, .index, .word, .way, .we(dataWe), .mask, .wdata(dataWdata), .rdata(cacheRdata)
  );

  dcacheController controller (
    .clk, .reset, .reqValid, .reqReady, .req, .respBusy, .look, .index, .newTag,
    .tagWe, .tagWay, .setDirty, .clearDirty, .touchWay, .touch, .word, .way, .dataWe,
    .mask, .dataWdata, .cacheRdata, .memValid, .memReady, .mem, .memRdata,
    .finish, .finishResp
  );

  dcacheResponse response (
    .clk, .reset, .finish, .finishResp, .respValid, .respReady, .resp, .respBusy
  );

endmodule
